// ==== Makefile ====
TOP = dcache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f dcache.f -o sim_$(TOP)

run: compile
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== dcache.f ====
hdl/dcache_pkg.sv
hdl/way_lookup.sv
hdl/plru_state.sv
hdl/cache_mem.sv
hdl/victim_buffer.sv
hdl/dcache_top.sv
sim/clock_gen.sv
sim/dcache_assert.sv
sim/dcache_tb.sv

// ==== hdl/cache_mem.sv ====
// set-associative line array
`timescale 1ns/1ps

module cache_mem
  import dcache_pkg::*;
(
  input  logic                              clock,
  input  logic                              reset,
  input  rd_req_t [rd_ports-1:0]            rd_req,
  input  wr_req_t [wr_ports-1:0]            wr_req,
  output logic [rd_ports-1:0][63:0]         rd_data,
  output lookup_e [rd_ports-1:0]            rd_result,
  output logic [wr_ports-1:0]               wr_miss,
  output evict_t [wr_ports-1:0]             evict,
  output touch_t [wr_ports+rd_ports-1:0]    touch,
  output logic [wr_ports-1:0]               alloc_en,
  output logic [wr_ports-1:0][set_bits-1:0] alloc_idx,
  input  way_t [wr_ports-1:0]               alloc_way
);

  cache_line_t [num_ways-1:0] lines [num_sets];

  logic [rd_ports-1:0] rd_hit;
  way_t [rd_ports-1:0] rd_way;
  logic [wr_ports-1:0] wr_hit;
  way_t [wr_ports-1:0] wr_hit_way;
  way_t [wr_ports-1:0] wr_way;

  for (genvar r = 0; r < rd_ports; r++) begin : g_rd_look
    way_lookup u_look (
      .en        (rd_req[r].en),
      .tag       (rd_req[r].tag),
      .set_lines (lines[rd_req[r].idx]),
      .hit       (rd_hit[r]),
      .way       (rd_way[r])
    );
  end

  for (genvar p = 0; p < wr_ports; p++) begin : g_wr_look
    way_lookup u_look (
      .en        (wr_req[p].en),
      .tag       (wr_req[p].tag),
      .set_lines (lines[wr_req[p].idx]),
      .hit       (wr_hit[p]),
      .way       (wr_hit_way[p])
    );
  end

  // read side, same-cycle write data overrides the array
  always_comb begin
    for (int r = 0; r < rd_ports; r++) begin
      rd_result[r] = look_miss;
      rd_data[r]   = '0;
      if (rd_hit[r]) begin
        rd_result[r] = look_hit;
        rd_data[r]   = lines[rd_req[r].idx][rd_way[r]].data;
      end
      for (int p = 0; p < wr_ports; p++) begin
        if (rd_req[r].en && wr_req[p].en &&
            (wr_req[p].idx == rd_req[r].idx) && (wr_req[p].tag == rd_req[r].tag)) begin
          rd_result[r] = look_forward;
          rd_data[r]   = wr_req[p].data;
        end
      end
    end
  end

  // write side, hit overwrites in place, miss takes the lru way
  always_comb begin
    for (int p = 0; p < wr_ports; p++) begin
      wr_miss[p]   = wr_req[p].en && !wr_hit[p];
      wr_way[p]    = wr_hit[p] ? wr_hit_way[p] : alloc_way[p];
      alloc_en[p]  = wr_miss[p];
      alloc_idx[p] = wr_req[p].idx;

      evict[p].idx   = wr_req[p].idx;
      evict[p].line  = lines[wr_req[p].idx][alloc_way[p]];
      evict[p].valid = wr_miss[p] && evict[p].line.valid;

      touch[p].en  = wr_hit[p];
      touch[p].idx = wr_req[p].idx;
      touch[p].way = wr_hit_way[p];
    end
    // only array hits count as a use on the read side
    for (int r = 0; r < rd_ports; r++) begin
      touch[wr_ports+r].en  = rd_hit[r];
      touch[wr_ports+r].idx = rd_req[r].idx;
      touch[wr_ports+r].way = rd_way[r];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < num_sets; s++) begin
        for (int w = 0; w < num_ways; w++) begin
          lines[s][w].valid <= 1'b0;
        end
      end
    end else begin
      // port 1 lands last on a collision
      for (int p = 0; p < wr_ports; p++) begin
        if (wr_req[p].en) begin
          lines[wr_req[p].idx][wr_way[p]] <= '{
            data:  wr_req[p].data,
            tag:   wr_req[p].tag,
            valid: 1'b1,
            dirty: wr_req[p].dirty
          };
        end
      end
    end
  end

endmodule

// ==== hdl/dcache_pkg.sv ====
// data cache shared definitions
package dcache_pkg;

  // geometry
  localparam int num_ways = 4;
  localparam int num_sets = 8;
  localparam int set_bits = 3;
  localparam int tag_bits = 10;
  localparam int rd_ports = 2;
  localparam int wr_ports = 2;
  localparam int vb_depth = 4;

  typedef logic [$clog2(num_ways)-1:0] way_t;

  typedef struct packed {
    logic [63:0]         data;
    logic [tag_bits-1:0] tag;
    logic                valid;
    logic                dirty;
  } cache_line_t;

  typedef struct packed {
    logic                en;
    logic [set_bits-1:0] idx;
    logic [tag_bits-1:0] tag;
  } rd_req_t;

  typedef struct packed {
    logic                en;
    logic [set_bits-1:0] idx;
    logic [tag_bits-1:0] tag;
    logic [63:0]         data;
    logic                dirty;
  } wr_req_t;

  typedef struct packed {
    logic [63:0] data;
    logic        valid;
    logic        miss;
  } rd_resp_t;

  // a line leaving the array, or leaving the victim buffer
  typedef struct packed {
    logic                valid;
    logic [set_bits-1:0] idx;
    cache_line_t         line;
  } evict_t;

  typedef enum logic [1:0] {
    look_miss,
    look_hit,
    look_forward
  } lookup_e;

  typedef struct packed {
    logic                en;
    logic [set_bits-1:0] idx;
    way_t                way;
  } touch_t;

endpackage

// ==== hdl/dcache_top.sv ====
// data cache storage top
`timescale 1ns/1ps

module dcache_top
  import dcache_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  rd_req_t [rd_ports-1:0] rd_req,
  input  wr_req_t [wr_ports-1:0] wr_req,
  output rd_resp_t [rd_ports-1:0] rd_resp,
  output logic [wr_ports-1:0]    wr_miss,
  output evict_t [wr_ports-1:0]  writeback
);

  logic [rd_ports-1:0][63:0]         rd_data;
  lookup_e [rd_ports-1:0]            rd_result;
  evict_t [wr_ports-1:0]             evict;
  touch_t [wr_ports+rd_ports-1:0]    touch;
  logic [wr_ports-1:0]               alloc_en;
  logic [wr_ports-1:0][set_bits-1:0] alloc_idx;
  way_t [wr_ports-1:0]               alloc_way;
  logic [rd_ports-1:0]               rd_miss;
  logic [rd_ports-1:0][set_bits-1:0] rd_idx;
  logic [rd_ports-1:0][tag_bits-1:0] rd_tag;
  logic [rd_ports-1:0][63:0]         vb_data;
  logic [rd_ports-1:0]               vb_hit;

  cache_mem u_mem (
    .clock     (clock),
    .reset     (reset),
    .rd_req    (rd_req),
    .wr_req    (wr_req),
    .rd_data   (rd_data),
    .rd_result (rd_result),
    .wr_miss   (wr_miss),
    .evict     (evict),
    .touch     (touch),
    .alloc_en  (alloc_en),
    .alloc_idx (alloc_idx),
    .alloc_way (alloc_way)
  );

  // lru bits sit next to the array they steer
  plru_state u_plru (
    .clock     (clock),
    .reset     (reset),
    .touch     (touch),
    .alloc_en  (alloc_en),
    .alloc_idx (alloc_idx),
    .alloc_way (alloc_way)
  );

  victim_buffer u_vb (
    .clock     (clock),
    .reset     (reset),
    .evict     (evict),
    .wr_req    (wr_req),
    .rd_miss   (rd_miss),
    .rd_idx    (rd_idx),
    .rd_tag    (rd_tag),
    .vb_data   (vb_data),
    .vb_hit    (vb_hit),
    .writeback (writeback)
  );

  // array answer first, victim buffer only on an array miss
  always_comb begin
    for (int r = 0; r < rd_ports; r++) begin
      rd_miss[r]       = rd_req[r].en && (rd_result[r] == look_miss);
      rd_idx[r]        = rd_req[r].idx;
      rd_tag[r]        = rd_req[r].tag;
      rd_resp[r].valid = (rd_result[r] != look_miss) || vb_hit[r];
      rd_resp[r].data  = vb_hit[r] ? vb_data[r] : rd_data[r];
      rd_resp[r].miss  = rd_req[r].en && !rd_resp[r].valid;
    end
  end

endmodule

// ==== hdl/plru_state.sv ====
// tree pseudo-lru state
`timescale 1ns/1ps

module plru_state
  import dcache_pkg::*;
(
  input  logic                               clock,
  input  logic                               reset,
  input  touch_t [wr_ports+rd_ports-1:0]     touch,
  input  logic [wr_ports-1:0]                alloc_en,
  input  logic [wr_ports-1:0][set_bits-1:0]  alloc_idx,
  output way_t [wr_ports-1:0]                alloc_way
);

  // bit 0 root, bit 1 ways 0-1, bit 2 ways 2-3
  logic [num_sets-1:0][2:0] tree;
  logic [num_sets-1:0][2:0] tree_next;

  // root takes the upper-half flag, the half node takes the low way bit
  function automatic logic [2:0] touch_bits(input logic [2:0] bits, input way_t w);
    logic [2:0] res;
    res    = bits;
    res[0] = w[1];
    if (w[1]) begin
      res[2] = w[0];
    end else begin
      res[1] = w[0];
    end
    return res;
  endfunction

  always_comb begin
    tree_next = tree;
    alloc_way = '0;
    // write ports in order, each sees the bits left by the one before
    for (int p = 0; p < wr_ports; p++) begin
      if (alloc_en[p]) begin
        tree_next[alloc_idx[p]][0] = ~tree_next[alloc_idx[p]][0];
        if (tree_next[alloc_idx[p]][0]) begin
          // new root 1, lower half
          tree_next[alloc_idx[p]][1] = ~tree_next[alloc_idx[p]][1];
          alloc_way[p] = {1'b0, ~tree_next[alloc_idx[p]][1]};
        end else begin
          tree_next[alloc_idx[p]][2] = ~tree_next[alloc_idx[p]][2];
          alloc_way[p] = {1'b1, ~tree_next[alloc_idx[p]][2]};
        end
      end
      if (touch[p].en) begin
        tree_next[touch[p].idx] = touch_bits(tree_next[touch[p].idx], touch[p].way);
      end
    end
    // read hits last
    for (int r = wr_ports; r < wr_ports + rd_ports; r++) begin
      if (touch[r].en) begin
        tree_next[touch[r].idx] = touch_bits(tree_next[touch[r].idx], touch[r].way);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tree <= '0;
    end else begin
      tree <= tree_next;
    end
  end

endmodule

// ==== hdl/victim_buffer.sv ====
// oldest-first victim buffer
`timescale 1ns/1ps

module victim_buffer
  import dcache_pkg::*;
(
  input  logic                              clock,
  input  logic                              reset,
  input  evict_t [wr_ports-1:0]             evict,
  input  wr_req_t [wr_ports-1:0]            wr_req,
  input  logic [rd_ports-1:0]               rd_miss,
  input  logic [rd_ports-1:0][set_bits-1:0] rd_idx,
  input  logic [rd_ports-1:0][tag_bits-1:0] rd_tag,
  output logic [rd_ports-1:0][63:0]         vb_data,
  output logic [rd_ports-1:0]               vb_hit,
  output evict_t [wr_ports-1:0]             writeback
);

  // entry 0 is the oldest
  evict_t [vb_depth-1:0]          entries;
  evict_t [vb_depth-1:0]          entries_next;
  evict_t [vb_depth+wr_ports-1:0] work;
  evict_t [wr_ports-1:0]          wb_next;
  logic [vb_depth-1:0]            stale;
  int unsigned                    fill;
  int unsigned                    spill;

  always_comb begin
    work = '0;
    fill = 0;
    // survivors packed to the front, stale copies dropped
    for (int i = 0; i < vb_depth; i++) begin
      stale[i] = 1'b0;
      for (int p = 0; p < wr_ports; p++) begin
        if (wr_req[p].en && (wr_req[p].idx == entries[i].idx) &&
            (wr_req[p].tag == entries[i].line.tag)) begin
          stale[i] = 1'b1;
        end
      end
      if (entries[i].valid && !stale[i]) begin
        work[fill] = entries[i];
        fill = fill + 1;
      end
    end
    // new victims behind them, port 0 first
    for (int p = 0; p < wr_ports; p++) begin
      if (evict[p].valid) begin
        work[fill] = evict[p];
        fill = fill + 1;
      end
    end
    spill = (fill > vb_depth) ? fill - vb_depth : 0;
    for (int i = 0; i < vb_depth; i++) begin
      entries_next[i] = work[i+spill];
    end
    // pushed-out lines leave through writeback only when dirty
    for (int k = 0; k < wr_ports; k++) begin
      wb_next[k]       = work[k];
      wb_next[k].valid = (k < spill) && work[k].line.dirty;
    end
  end

  always_comb begin
    for (int r = 0; r < rd_ports; r++) begin
      vb_hit[r]  = 1'b0;
      vb_data[r] = '0;
      for (int i = 0; i < vb_depth; i++) begin
        if (rd_miss[r] && entries[i].valid && (entries[i].idx == rd_idx[r]) &&
            (entries[i].line.tag == rd_tag[r])) begin
          vb_hit[r]  = 1'b1;
          vb_data[r] = entries[i].line.data;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < vb_depth; i++) begin
        entries[i].valid <= 1'b0;
      end
      for (int k = 0; k < wr_ports; k++) begin
        writeback[k].valid <= 1'b0;
      end
    end else begin
      entries   <= entries_next;
      writeback <= wb_next;
    end
  end

endmodule

// ==== hdl/way_lookup.sv ====
// set tag compare
`timescale 1ns/1ps

module way_lookup
  import dcache_pkg::*;
(
  input  logic                       en,
  input  logic [tag_bits-1:0]        tag,
  input  cache_line_t [num_ways-1:0] set_lines,
  output logic                       hit,
  output way_t                       way
);

  logic [num_ways-1:0] match;

  // one compare per way, valid lines only
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      match[w] = en && set_lines[w].valid && (set_lines[w].tag == tag);
    end
  end

  assign hit = |match;

  // lowest matching way wins, a set never holds a tag twice
  always_comb begin
    way = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (match[w]) begin
        way = way_t'(w);
      end
    end
  end

endmodule

// ==== sim/clock_gen.sv ====
// testbench clock and reset
`timescale 1ns/1ps

module clock_gen (
  output logic clock,
  output logic reset
);

  // 20 ns period
  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

// ==== sim/dcache_assert.sv ====
// data cache output assertions
`timescale 1ns/1ps

module dcache_assert
  import dcache_pkg::*;
(
  input logic                    clock,
  input logic                    reset,
  input rd_req_t [rd_ports-1:0]  rd_req,
  input rd_resp_t [rd_ports-1:0] rd_resp,
  input evict_t [wr_ports-1:0]   writeback
);

  int fail_count = 0;

  for (genvar r = 0; r < rd_ports; r++) begin : g_rd
    // a read either returns data or misses, never both
    a_valid_or_miss: assert property (@(posedge clock) disable iff (reset)
        !(rd_resp[r].valid && rd_resp[r].miss))
      else begin
        fail_count++;
        $error("read port %0d shows valid and miss together", r);
      end

    a_miss_needs_en: assert property (@(posedge clock) disable iff (reset)
        rd_resp[r].miss |-> rd_req[r].en)
      else begin
        fail_count++;
        $error("read port %0d reports a miss without a request", r);
      end
  end

  for (genvar k = 0; k < wr_ports; k++) begin : g_wb
    // only dirty lines leave through writeback
    a_wb_dirty: assert property (@(posedge clock) disable iff (reset)
        writeback[k].valid |-> writeback[k].line.dirty)
      else begin
        fail_count++;
        $error("writeback %0d carries a clean line", k);
      end
  end

endmodule

bind dcache_top dcache_assert u_assert (
  .clock     (clock),
  .reset     (reset),
  .rd_req    (rd_req),
  .rd_resp   (rd_resp),
  .writeback (writeback)
);

// ==== sim/dcache_tb.sv ====
// data cache testbench
`timescale 1ns/1ps

module dcache_tb
  import dcache_pkg::*;
();

  typedef struct packed {
    rd_req_t [rd_ports-1:0]  rd;
    wr_req_t [wr_ports-1:0]  wr;
    rd_resp_t [rd_ports-1:0] resp;
    logic [wr_ports-1:0]     wmiss;
    evict_t [wr_ports-1:0]   wb;
  } row_t;

  logic                    clock;
  logic                    reset;
  rd_req_t [rd_ports-1:0]  rd_req;
  wr_req_t [wr_ports-1:0]  wr_req;
  rd_resp_t [rd_ports-1:0] rd_resp;
  logic [wr_ports-1:0]     wr_miss;
  evict_t [wr_ports-1:0]   writeback;

  row_t        rows[$];
  row_t        cur;
  logic [63:0] dw [22];
  logic [31:0] seed = 32'd84362;
  int          errors = 0;
  int          cur_row = 0;
  logic        table_ready = 1'b0;

  clock_gen u_clock (
    .clock (clock),
    .reset (reset)
  );

  dcache_top uut (
    .clock     (clock),
    .reset     (reset),
    .rd_req    (rd_req),
    .wr_req    (wr_req),
    .rd_resp   (rd_resp),
    .wr_miss   (wr_miss),
    .writeback (writeback)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      errors++;
      $display("[FAIL] row %0d %s: got 0x%h, expected 0x%h", cur_row, name, got, want);
    end
  endtask

  task automatic add_read(input int p, input logic [set_bits-1:0] idx,
                          input logic [tag_bits-1:0] tag, input logic valid,
                          input logic [63:0] data);
    cur.rd[p].en       = 1'b1;
    cur.rd[p].idx      = idx;
    cur.rd[p].tag      = tag;
    cur.resp[p].valid  = valid;
    cur.resp[p].miss   = !valid;
    cur.resp[p].data   = valid ? data : '0;
  endtask

  task automatic add_write(input int p, input logic [set_bits-1:0] idx,
                           input logic [tag_bits-1:0] tag, input logic [63:0] data,
                           input logic dirty, input logic miss);
    cur.wr[p].en    = 1'b1;
    cur.wr[p].idx   = idx;
    cur.wr[p].tag   = tag;
    cur.wr[p].data  = data;
    cur.wr[p].dirty = dirty;
    cur.wmiss[p]    = miss;
  endtask

  task automatic add_writeback(input int p, input logic [set_bits-1:0] idx,
                               input logic [tag_bits-1:0] tag, input logic [63:0] data);
    cur.wb[p].valid     = 1'b1;
    cur.wb[p].idx       = idx;
    cur.wb[p].line.tag  = tag;
    cur.wb[p].line.data = data;
  endtask

  task automatic end_row();
    rows.push_back(cur);
    cur = '0;
  endtask

  task automatic fill_words();
    logic [31:0] hi;
    for (int i = 0; i < 22; i++) begin
      seed  = lcg_next(seed);
      hi    = seed;
      seed  = lcg_next(seed);
      dw[i] = {hi, seed};
    end
  endtask

  // lru walk in set 2: fresh set fills ways 0, 2, 1, 3
  task automatic build_table();
    cur = '0;
    end_row();
    // empty cache misses everywhere
    add_read(0, 3'd1, 10'h010, 1'b0, '0);
    add_read(1, 3'd5, 10'h020, 1'b0, '0);
    end_row();
    // same-cycle write is forwarded
    add_write(0, 3'd1, 10'h010, dw[0], 1'b0, 1'b1);
    add_read(0, 3'd1, 10'h010, 1'b1, dw[0]);
    end_row();
    add_read(0, 3'd1, 10'h010, 1'b1, dw[0]);
    add_write(0, 3'd2, 10'h101, dw[1], 1'b1, 1'b1);
    add_write(1, 3'd2, 10'h102, dw[2], 1'b1, 1'b1);
    end_row();
    add_write(0, 3'd2, 10'h103, dw[3], 1'b1, 1'b1);
    add_write(1, 3'd2, 10'h104, dw[4], 1'b1, 1'b1);
    end_row();
    // fifth tag lands in way 0 and evicts 0x101
    add_write(0, 3'd2, 10'h105, dw[5], 1'b1, 1'b1);
    end_row();
    // 0x101 from the victim buffer, 0x105 hit touches way 0
    add_read(0, 3'd2, 10'h101, 1'b1, dw[1]);
    add_read(1, 3'd2, 10'h105, 1'b1, dw[5]);
    end_row();
    // after the touch the miss picks way 0 again, 0x105 goes out
    add_write(0, 3'd2, 10'h106, dw[6], 1'b1, 1'b1);
    end_row();
    add_read(0, 3'd2, 10'h105, 1'b1, dw[5]);
    add_write(0, 3'd2, 10'h107, dw[7], 1'b1, 1'b1);
    add_write(1, 3'd2, 10'h108, dw[8], 1'b0, 1'b1);
    end_row();
    // buffer full, oldest dirty entry pushed out
    add_write(0, 3'd2, 10'h109, dw[9], 1'b0, 1'b1);
    end_row();
    add_writeback(0, 3'd2, 10'h101, dw[1]);
    add_write(0, 3'd2, 10'h10a, dw[10], 1'b0, 1'b1);
    end_row();
    add_writeback(0, 3'd2, 10'h105, dw[5]);
    add_write(0, 3'd2, 10'h10b, dw[11], 1'b0, 1'b1);
    add_write(1, 3'd2, 10'h10c, dw[12], 1'b0, 1'b1);
    end_row();
    add_writeback(0, 3'd2, 10'h102, dw[2]);
    add_writeback(1, 3'd2, 10'h103, dw[3]);
    add_write(0, 3'd2, 10'h10d, dw[13], 1'b0, 1'b1);
    end_row();
    // rewrite 0x108 while its old copy sits in the buffer
    add_writeback(0, 3'd2, 10'h104, dw[4]);
    add_write(0, 3'd2, 10'h108, dw[14], 1'b1, 1'b1);
    add_read(1, 3'd2, 10'h108, 1'b1, dw[14]);
    end_row();
    add_read(0, 3'd2, 10'h108, 1'b1, dw[14]);
    add_write(0, 3'd2, 10'h10e, dw[15], 1'b0, 1'b1);
    end_row();
    add_writeback(0, 3'd2, 10'h106, dw[6]);
    add_write(0, 3'd2, 10'h10f, dw[16], 1'b0, 1'b1);
    end_row();
    // clean lines pushed out, writeback stays quiet next row
    add_writeback(0, 3'd2, 10'h107, dw[7]);
    add_write(0, 3'd2, 10'h110, dw[17], 1'b0, 1'b1);
    add_write(1, 3'd2, 10'h111, dw[18], 1'b0, 1'b1);
    end_row();
    add_write(0, 3'd2, 10'h112, dw[19], 1'b0, 1'b1);
    add_write(1, 3'd2, 10'h113, dw[20], 1'b0, 1'b1);
    end_row();
    // drained, 0x108 is gone everywhere
    add_writeback(1, 3'd2, 10'h108, dw[14]);
    add_read(0, 3'd2, 10'h108, 1'b0, '0);
    add_read(1, 3'd2, 10'h113, 1'b1, dw[20]);
    add_write(0, 3'd1, 10'h010, dw[21], 1'b0, 1'b0);
    end_row();
    add_read(0, 3'd1, 10'h010, 1'b1, dw[21]);
    end_row();
  endtask

  task automatic check_row(input row_t want);
    for (int r = 0; r < rd_ports; r++) begin
      check_value($sformatf("rd_resp[%0d].valid", r), 64'(rd_resp[r].valid),
                  64'(want.resp[r].valid));
      check_value($sformatf("rd_resp[%0d].miss", r), 64'(rd_resp[r].miss),
                  64'(want.resp[r].miss));
      if (want.resp[r].valid) begin
        check_value($sformatf("rd_resp[%0d].data", r), rd_resp[r].data, want.resp[r].data);
      end
    end
    for (int p = 0; p < wr_ports; p++) begin
      check_value($sformatf("wr_miss[%0d]", p), 64'(wr_miss[p]), 64'(want.wmiss[p]));
      check_value($sformatf("writeback[%0d].valid", p), 64'(writeback[p].valid),
                  64'(want.wb[p].valid));
      if (want.wb[p].valid) begin
        check_value($sformatf("writeback[%0d].idx", p), 64'(writeback[p].idx),
                    64'(want.wb[p].idx));
        check_value($sformatf("writeback[%0d].tag", p), 64'(writeback[p].line.tag),
                    64'(want.wb[p].line.tag));
        check_value($sformatf("writeback[%0d].data", p), writeback[p].line.data,
                    want.wb[p].line.data);
      end
    end
  endtask

  initial begin
    rd_req = '0;
    wr_req = '0;
    fill_words();
    build_table();
    table_ready = 1'b1;
    wait (reset == 1'b0);
    for (int i = 0; i < rows.size(); i++) begin
      @(negedge clock);
      cur_row = i;
      rd_req  = rows[i].rd;
      wr_req  = rows[i].wr;
      // outputs settle well before the next rising edge
      #5;
      check_row(rows[i]);
    end
    @(negedge clock);
    errors = errors + uut.u_assert.fail_count;
    $display("%0d rows applied, %0d errors", rows.size(), errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // one clock per row plus reset and slack
  initial begin
    int limit;
    wait (table_ready);
    limit = (rows.size() + 8) * 20;
    #(limit);
    $display("watchdog expired: rows not finished after %0d ns", limit);
    $display("Finished with errors");
    $finish;
  end

endmodule
